// File: hidden_gate_golden.txt
# Test header: name, vector size, mode (0 gaps, 1 back-to-back, 2 restart+extras, 3 lone strobes)
# Element lines: s, o, expected h, all Q4.12 in hex
basic 4 0
0800 1000 0765
0400 2000 0766
f800 0800 fc4e
1800 1000 0e7b
saturate 5 1
4000 1234 1234
c000 0321 fcdf
7fff 8000 8000
8000 8000 7fff
5000 f001 f001
empty 0 2
rounding 6 1
0800 ffff 0000
0800 0001 0000
1000 0002 0002
2000 7fff 7b67
e000 8000 7b68
f000 0003 fffe
restart 3 2
0c00 1000 09ca
3800 1000 0ff9
3fff f000 f003
lone_strobe 3 3
2c00 1000 0fda
3400 0800 07fa
2400 e000 e0ca

// File: hidden_gate_pkg.sv
// Hidden gate package: Q4.12 widths, saturation bounds, latencies and tanh segment tables

package hidden_gate_pkg;

  ////////////////////////////////////////////////////////////
  // Number format
  ////////////////////////////////////////////////////////////

  // Signed Q4.12 element
  localparam int DATA_WIDTH = 16;
  localparam int FRAC_BITS  = 12;

  // Vector length, up to 255 elements
  localparam int SIZE_WIDTH = 8;

  // 1.0, also the tanh saturation level
  localparam int ONE_FIXED  = 1 << FRAC_BITS;
  localparam int MAX_FIXED  = (1 << (DATA_WIDTH - 1)) - 1;
  localparam int MIN_FIXED  = -(1 << (DATA_WIDTH - 1));

  // Half an LSB of the fraction, added before truncation
  localparam int ROUND_HALF = 1 << (FRAC_BITS - 1);

  ////////////////////////////////////////////////////////////
  // Tanh segmentation
  ////////////////////////////////////////////////////////////

  // Eight segments of width 0.5 over |x| < 4
  localparam int TANH_SEGMENTS = 8;
  localparam int SEG_IDX_BITS  = $clog2(TANH_SEGMENTS);
  // Position inside a segment, 0.5 = 2^(FRAC_BITS-1)
  localparam int SEG_POS_BITS  = FRAC_BITS - 1;

  // Pipeline depths
  localparam int TANH_LATENCY = 2;
  localparam int MULT_LATENCY = 1;

  // Controller states
  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_BUSY = 1'b1;

  // Secant slope of tanh across segment idx
  function automatic logic [DATA_WIDTH-1:0] tanh_slope(input logic [SEG_IDX_BITS-1:0] idx);
    case (idx)
      3'd0:    tanh_slope = 16'd3786;
      3'd1:    tanh_slope = 16'd2453;
      3'd2:    tanh_slope = 16'd1176;
      3'd3:    tanh_slope = 16'd482;
      3'd4:    tanh_slope = 16'd185;
      3'd5:    tanh_slope = 16'd69;
      3'd6:    tanh_slope = 16'd26;
      default: tanh_slope = 16'd9;
    endcase
  endfunction

  // Tanh at the segment start, idx * 0.5
  function automatic logic [DATA_WIDTH-1:0] tanh_offset(input logic [SEG_IDX_BITS-1:0] idx);
    case (idx)
      3'd0:    tanh_offset = 16'd0;
      3'd1:    tanh_offset = 16'd1893;
      3'd2:    tanh_offset = 16'd3119;
      3'd3:    tanh_offset = 16'd3707;
      3'd4:    tanh_offset = 16'd3949;
      3'd5:    tanh_offset = 16'd4041;
      3'd6:    tanh_offset = 16'd4076;
      default: tanh_offset = 16'd4089;
    endcase
  endfunction

endpackage

// File: hidden_gate_vector.sv
// Hidden gate controller: streams h = o * tanh(s) element by element over one vector
`timescale 1ns/100ps

module hidden_gate_vector import hidden_gate_pkg::*; (
  input  logic                  CLK,
  input  logic                  RST,

  // Control
  input  logic                  START,
  output logic                  READY,

  input  logic                  S_IN_ENABLE,
  input  logic                  O_IN_ENABLE,

  // Data
  input  logic [SIZE_WIDTH-1:0] SIZE_L_IN,
  input  logic [DATA_WIDTH-1:0] S_IN,
  input  logic [DATA_WIDTH-1:0] O_IN,

  output logic                  H_OUT_ENABLE,
  output logic [DATA_WIDTH-1:0] H_OUT
);

  ////////////////////////////////////////////////////////////
  // Signals
  ////////////////////////////////////////////////////////////

  // Controller
  logic                  state;
  logic [SIZE_WIDTH-1:0] size_q;
  logic [SIZE_WIDTH-1:0] in_count;
  logic [SIZE_WIDTH-1:0] out_count;
  logic                  accept;
  logic                  last_out;

  // o held back to meet tanh(s)
  logic [DATA_WIDTH-1:0] o_pipe [TANH_LATENCY];

  // Tanh unit
  logic                  tanh_valid;
  logic [DATA_WIDTH-1:0] tanh_data;

  // Multiplier
  logic                  mult_valid;
  logic [DATA_WIDTH-1:0] mult_data;

  ////////////////////////////////////////////////////////////
  // Accept and completion
  ////////////////////////////////////////////////////////////

  // Both strobes together, and only up to the latched size
  assign accept = (state == ST_BUSY) && S_IN_ENABLE && O_IN_ENABLE &&
                  (in_count < size_q);

  // Next tanh result is the final element
  assign last_out = (out_count == size_q - SIZE_WIDTH'(1));

  ////////////////////////////////////////////////////////////
  // Controller FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state     <= ST_IDLE;
      size_q    <= '0;
      in_count  <= '0;
      out_count <= '0;
      READY     <= 1'b0;
    end else begin
      // One-cycle pulse
      READY <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (START) begin
            size_q    <= SIZE_L_IN;
            in_count  <= '0;
            out_count <= '0;
            // Empty vector finishes at once
            if (SIZE_L_IN == '0) begin
              READY <= 1'b1;
            end else begin
              state <= ST_BUSY;
            end
          end
        end

        ST_BUSY: begin
          // START is ignored here
          if (accept) begin
            in_count <= in_count + SIZE_WIDTH'(1);
          end
          // Counted as results enter the multiplier, so READY
          // registers on the same edge as the last product
          if (tanh_valid) begin
            out_count <= out_count + SIZE_WIDTH'(1);
            if (last_out) begin
              READY <= 1'b1;
              state <= ST_IDLE;
            end
          end
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // o delay line
  ////////////////////////////////////////////////////////////

  // Free-running shift, one stage per tanh stage
  always_ff @(posedge CLK) begin
    o_pipe[0] <= O_IN;
    for (int i = 1; i < TANH_LATENCY; i++) begin
      o_pipe[i] <= o_pipe[i-1];
    end
  end

  ////////////////////////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////////////////////////

  // tanh(s)
  vector_tanh_function tanh_unit (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_IN_ENABLE (accept),
    .DATA_IN        (S_IN),
    .DATA_OUT_ENABLE(tanh_valid),
    .DATA_OUT       (tanh_data)
  );

  // o * tanh(s)
  vector_fixed_multiplier multiplier_unit (
    .CLK            (CLK),
    .RST            (RST),
    .DATA_IN_ENABLE (tanh_valid),
    .DATA_A_IN      (o_pipe[TANH_LATENCY-1]),
    .DATA_B_IN      (tanh_data),
    .DATA_OUT_ENABLE(mult_valid),
    .DATA_OUT       (mult_data)
  );

  // Products leave in input order
  assign H_OUT_ENABLE = mult_valid;
  assign H_OUT        = mult_data;

endmodule

// File: hidden_gate_vector_tb.sv
// Testbench for the hidden gate vector unit, stimulus and expected h from a golden file
`timescale 1ns/100ps

module hidden_gate_vector_tb import hidden_gate_pkg::*; ();

  logic                  CLK;
  logic                  RST;
  logic                  start;
  logic                  ready;
  logic                  s_in_enable;
  logic                  o_in_enable;
  logic [SIZE_WIDTH-1:0] size_l_in;
  logic [DATA_WIDTH-1:0] s_in;
  logic [DATA_WIDTH-1:0] o_in;
  logic                  h_out_enable;
  logic [DATA_WIDTH-1:0] h_out;

  // Golden tests, elements flattened in file order
  string                 test_name [$];
  int                    test_size [$];
  int                    test_mode [$];
  logic [DATA_WIDTH-1:0] gold_s [$];
  logic [DATA_WIDTH-1:0] gold_o [$];
  logic [DATA_WIDTH-1:0] gold_h [$];

  // Monitor results
  logic [DATA_WIDTH-1:0] h_seen [$];
  int                    ready_count;
  int                    ready_outputs;
  logic                  ready_with_h;

  logic [31:0] lfsr_state;
  int          cycle_count = 0;
  int          cycle_limit = 0;
  int          error_count;
  int          test_errors;
  int          fail_count;

  hidden_gate_vector dut0 (
    .CLK         (CLK),
    .RST         (RST),
    .START       (start),
    .READY       (ready),
    .S_IN_ENABLE (s_in_enable),
    .O_IN_ENABLE (o_in_enable),
    .SIZE_L_IN   (size_l_in),
    .S_IN        (s_in),
    .O_IN        (o_in),
    .H_OUT_ENABLE(h_out_enable),
    .H_OUT       (h_out)
  );

  always #4 CLK = ~CLK;

  // Outputs are registered, mid-cycle they are settled
  always @(negedge CLK) begin
    if (h_out_enable) begin
      h_seen.push_back(h_out);
    end
    if (ready) begin
      ready_count++;
      // Outputs so far, and whether the last one shares this cycle
      ready_outputs = h_seen.size();
      ready_with_h  = h_out_enable;
    end
  end

  // Watchdog
  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("Timeout: the run went past %0d cycles", cycle_limit);
      $display("Done: errors found");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
  endfunction

  // Idle gap of 0..3, one LFSR step per bit
  function automatic int draw_gap();
    int gap;
    gap = 0;
    for (int i = 0; i < 2; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      gap = (gap << 1) | lfsr_state[0];
    end
    return gap;
  endfunction

  task automatic drive_cycle(input logic se, input logic oe,
                             input logic [DATA_WIDTH-1:0] s, input logic [DATA_WIDTH-1:0] o);
    @(posedge CLK);
    start       <= 1'b0;
    s_in_enable <= se;
    o_in_enable <= oe;
    s_in        <= s;
    o_in        <= o;
  endtask

  task automatic pulse_start(input logic [SIZE_WIDTH-1:0] size);
    @(posedge CLK);
    start       <= 1'b1;
    size_l_in   <= size;
    s_in_enable <= 1'b0;
    o_in_enable <= 1'b0;
  endtask

  task automatic check_data(input string name, input logic [DATA_WIDTH-1:0] expected,
                            input logic [DATA_WIDTH-1:0] actual);
    if (actual !== expected) begin
      $display("ERR %s expected %h got %h", name, expected, actual);
      test_errors++;
    end
  endtask

  task automatic check_count(input string name, input string what, input int expected,
                             input int actual);
    if (actual != expected) begin
      $display("ERR %s expected %0d %s got %0d", name, expected, what, actual);
      test_errors++;
    end
  endtask

  // Header line: name size mode, then size lines of s o h
  task automatic load_golden(output logic ok);
    int fd;
    int r;
    int left;
    int size;
    int mode;
    logic bad;
    string line;
    string name;
    logic [DATA_WIDTH-1:0] s;
    logic [DATA_WIDTH-1:0] o;
    logic [DATA_WIDTH-1:0] h;
    ok   = 1'b0;
    bad  = 1'b0;
    left = 0;
    fd   = $fopen("hidden_gate_golden.txt", "r");
    if (fd != 0) begin
      while ($fgets(line, fd)) begin
        if (line.len() > 1 && line.getc(0) != "#") begin
          if (left == 0) begin
            size = 0;
            r = $sscanf(line, "%s %d %d", name, size, mode);
            if (r != 3) begin
              bad = 1'b1;
            end
            test_name.push_back(name);
            test_size.push_back(size);
            test_mode.push_back(mode);
            cycle_limit += size * 4 + 20;
            left = size;
          end else begin
            r = $sscanf(line, "%h %h %h", s, o, h);
            if (r != 3) begin
              bad = 1'b1;
            end
            gold_s.push_back(s);
            gold_o.push_back(o);
            gold_h.push_back(h);
            left--;
          end
        end
      end
      $fclose(fd);
      ok = !bad && (test_name.size() > 0) && (left == 0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // One vector
  ////////////////////////////////////////////////////////////

  // Modes: 0 gaps, 1 back-to-back, 2 restart and extras, 3 lone strobes
  task automatic run_test(input int t, input int first);
    int    ready_before;
    int    waited;
    int    mode;
    string name;
    name          = test_name[t];
    mode          = test_mode[t];
    test_errors   = 0;
    h_seen.delete();
    ready_before  = ready_count;
    ready_outputs = -1;
    ready_with_h  = 1'b0;
    pulse_start(SIZE_WIDTH'(test_size[t]));
    for (int i = 0; i < test_size[t]; i++) begin
      if (mode == 2 && i == 1) begin
        pulse_start(SIZE_WIDTH'(test_size[t] + 4));
      end
      if (mode == 0 || mode == 2) begin
        repeat (draw_gap()) drive_cycle(1'b0, 1'b0, '0, '0);
      end
      // Only one strobe high, nothing taken
      if (mode == 3) begin
        drive_cycle(i % 2 == 0, i % 2 != 0, 16'h4000, 16'h7fff);
      end
      drive_cycle(1'b1, 1'b1, gold_s[first+i], gold_o[first+i]);
    end
    // Offered past the size
    if (mode == 2) begin
      drive_cycle(1'b1, 1'b1, 16'h4000, 16'h1111);
      drive_cycle(1'b1, 1'b1, 16'hc000, 16'h2222);
    end
    drive_cycle(1'b0, 1'b0, '0, '0);
    waited = 0;
    while (ready_count == ready_before && waited < 8) begin
      @(posedge CLK);
      waited++;
    end
    if (ready_count == ready_before) begin
      $display("%s: READY never came after the last element", name);
      test_errors++;
    end
    // Let stray outputs show up
    repeat (4) @(posedge CLK);
    check_count(name, "READY pulses", 1, ready_count - ready_before);
    check_count(name, "outputs", test_size[t], h_seen.size());
    // READY lines up with the last product
    check_count(name, "outputs by READY", test_size[t], ready_outputs);
    check_count(name, "outputs in the READY cycle", (test_size[t] != 0) ? 1 : 0,
                int'(ready_with_h));
    for (int i = 0; i < test_size[t] && i < h_seen.size(); i++) begin
      check_data(name, gold_h[first+i], h_seen[i]);
    end
    $display("%s: %s", name, (test_errors == 0) ? "pass" : "FAIL");
    if (test_errors != 0) begin
      fail_count++;
    end
    error_count += test_errors;
  endtask

  initial begin
    logic loaded;
    int   first;
    CLK           = 1'b0;
    RST           = 1'b1;
    start         = 1'b0;
    s_in_enable   = 1'b0;
    o_in_enable   = 1'b0;
    size_l_in     = '0;
    s_in          = '0;
    o_in          = '0;
    ready_count   = 0;
    ready_outputs = 0;
    ready_with_h  = 1'b0;
    error_count   = 0;
    fail_count    = 0;
    lfsr_state    = 32'he207;
    load_golden(loaded);
    if (!loaded) begin
      $display("The golden vector file could not be read or is malformed");
      error_count++;
    end else begin
      repeat (2) @(posedge CLK);
      RST <= 1'b0;
      @(posedge CLK);
      first = 0;
      for (int t = 0; t < test_name.size(); t++) begin
        run_test(t, first);
        first += test_size[t];
      end
    end
    $display("%0d tests, %0d failed, %0d errors", test_name.size(), fail_count, error_count);
    if (error_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: list.f
hidden_gate_pkg.sv
vector_tanh_function.sv
vector_fixed_multiplier.sv
hidden_gate_vector.sv
hidden_gate_vector_tb.sv

// File: vector_fixed_multiplier.sv
// Vector multiplier: element-wise Q4.12 product with round-to-nearest and saturation
`timescale 1ns/100ps

module vector_fixed_multiplier import hidden_gate_pkg::*; (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  DATA_IN_ENABLE,
  input  logic [DATA_WIDTH-1:0] DATA_A_IN,
  input  logic [DATA_WIDTH-1:0] DATA_B_IN,
  output logic                  DATA_OUT_ENABLE,
  output logic [DATA_WIDTH-1:0] DATA_OUT
);

  // Full-width product, Q8.24
  logic signed [2*DATA_WIDTH-1:0] product;
  logic signed [2*DATA_WIDTH-1:0] rounded;
  logic signed [2*DATA_WIDTH-1:0] shifted;
  logic        [DATA_WIDTH-1:0]   sat_result;

  // Output stages
  logic                  valid_pipe [MULT_LATENCY];
  logic [DATA_WIDTH-1:0] data_pipe  [MULT_LATENCY];

  always_comb begin
    product = $signed(DATA_A_IN) * $signed(DATA_B_IN);
    // Half LSB then arithmetic shift, ties go up
    rounded = product + (2*DATA_WIDTH)'(ROUND_HALF);
    shifted = rounded >>> FRAC_BITS;
    // Clip to the Q4.12 range
    if (shifted > MAX_FIXED) begin
      sat_result = DATA_WIDTH'(MAX_FIXED);
    end else if (shifted < MIN_FIXED) begin
      sat_result = DATA_WIDTH'(MIN_FIXED);
    end else begin
      sat_result = shifted[DATA_WIDTH-1:0];
    end
  end

  // Result register with its strobe
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      for (int i = 0; i < MULT_LATENCY; i++) begin
        valid_pipe[i] <= 1'b0;
        data_pipe[i]  <= '0;
      end
    end else begin
      valid_pipe[0] <= DATA_IN_ENABLE;
      data_pipe[0]  <= sat_result;
      for (int i = 1; i < MULT_LATENCY; i++) begin
        valid_pipe[i] <= valid_pipe[i-1];
        data_pipe[i]  <= data_pipe[i-1];
      end
    end
  end

  assign DATA_OUT_ENABLE = valid_pipe[MULT_LATENCY-1];
  assign DATA_OUT        = data_pipe[MULT_LATENCY-1];

endmodule

// File: vector_tanh_function.sv
// Vector tanh unit: two-stage piecewise-linear tanh on a stream of Q4.12 elements
`timescale 1ns/100ps

module vector_tanh_function import hidden_gate_pkg::*; (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  DATA_IN_ENABLE,
  input  logic [DATA_WIDTH-1:0] DATA_IN,
  output logic                  DATA_OUT_ENABLE,
  output logic [DATA_WIDTH-1:0] DATA_OUT
);

  localparam int PROD_WIDTH = DATA_WIDTH + SEG_POS_BITS;

  // Stage 1 values
  logic                    in_sign;
  logic [DATA_WIDTH-1:0]   in_abs;
  logic                    s1_valid;
  logic                    s1_sign;
  logic                    s1_sat;
  logic [DATA_WIDTH-1:0]   s1_abs;

  // Fields of the registered magnitude
  logic [SEG_IDX_BITS-1:0] seg_idx;
  logic [SEG_POS_BITS-1:0] seg_pos;

  // Stage 2 arithmetic
  logic [DATA_WIDTH-1:0]   slope;
  logic [DATA_WIDTH-1:0]   offs;
  logic [PROD_WIDTH-1:0]   prod;
  logic [DATA_WIDTH:0]     interp;
  logic [DATA_WIDTH-1:0]   mag;
  logic [DATA_WIDTH-1:0]   result;

  ////////////////////////////////////////////////////////////
  // Stage 1: sign and magnitude
  ////////////////////////////////////////////////////////////

  assign in_sign = DATA_IN[DATA_WIDTH-1];

  // -(-8.0) does not fit, clip to the largest positive value
  assign in_abs = !in_sign ? DATA_IN :
                  (DATA_IN == DATA_WIDTH'(MIN_FIXED)) ? DATA_WIDTH'(MAX_FIXED) : -DATA_IN;

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      s1_valid <= 1'b0;
    end else begin
      s1_valid <= DATA_IN_ENABLE;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge CLK) begin
    s1_sign <= in_sign;
    s1_abs  <= in_abs;
    // |x| >= 4.0 sits above the segment table
    s1_sat  <= in_abs[SEG_POS_BITS+SEG_IDX_BITS];
  end

  // Bits 13:11 pick the segment, 10:0 the place in it
  assign seg_idx = s1_abs[SEG_POS_BITS +: SEG_IDX_BITS];
  assign seg_pos = s1_abs[SEG_POS_BITS-1:0];

  ////////////////////////////////////////////////////////////
  // Stage 2: interpolate, clamp, restore sign
  ////////////////////////////////////////////////////////////

  always_comb begin
    slope  = tanh_slope(seg_idx);
    offs   = tanh_offset(seg_idx);
    // Slope times position, rounded to nearest
    prod   = slope * seg_pos + PROD_WIDTH'(ROUND_HALF);
    interp = {1'b0, offs} + (DATA_WIDTH + 1)'(prod >> FRAC_BITS);
    // Never above 1.0
    if (s1_sat || interp > (DATA_WIDTH + 1)'(ONE_FIXED)) begin
      mag = DATA_WIDTH'(ONE_FIXED);
    end else begin
      mag = interp[DATA_WIDTH-1:0];
    end
    // Odd function
    result = s1_sign ? -mag : mag;
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      DATA_OUT_ENABLE <= 1'b0;
    end else begin
      DATA_OUT_ENABLE <= s1_valid;
    end
  end

  always_ff @(posedge CLK) begin
    DATA_OUT <= result;
  end

endmodule
